/* run_sim.sh */
#!/bin/sh
# build and run the scene query testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_scene_query -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_scene_query > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
    echo "no pass message in $LOG"
    exit 1
fi
exit 0

/* source/scene_query.sv */
`timescale 1ns/1ps
`default_nettype none

module scene_query
    import sdf_pkg::*;
#(
    parameter fp SPHERE_RADIUS = FP_ONE,
    parameter fp FRAME_HALF    = FP_ONE,
    parameter fp FRAME_EDGE    = 32'h0040_0000
) (
    input  wire         clk,
    input  wire         reset,
    input  wire         valid_in,
    input  wire query_t query,
    output fp           distance,
    output logic        valid_out
);

    // what travels alongside each point
    typedef struct packed {
        logic valid;
        logic sel;
    } tag_t;

    tag_t tag_line [SCENE_LATENCY];
    tag_t tag_out;

    logic sphere_vin;
    logic box_vin;
    fp    sphere_dist;
    fp    box_dist;
    logic sphere_vout;
    logic box_vout;

    // steer each point to one object only
    assign sphere_vin = valid_in && !query.obj_sel;
    assign box_vin    = valid_in && query.obj_sel;

    sdf_sphere #(
        .SPHERE_RADIUS (SPHERE_RADIUS)
    ) u_sphere (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (sphere_vin),
        .p         (query.pos),
        .distance  (sphere_dist),
        .valid_out (sphere_vout)
    );

    sdf_box_frame #(
        .FRAME_HALF (FRAME_HALF),
        .FRAME_EDGE (FRAME_EDGE)
    ) u_box_frame (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (box_vin),
        .p         (query.pos),
        .distance  (box_dist),
        .valid_out (box_vout)
    );

    // select delay line, same depth as both objects
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < SCENE_LATENCY; k++) begin
                tag_line[k] <= '0;
            end
        end else begin
            tag_line[0] <= '{valid: valid_in, sel: query.obj_sel};
            for (int k = 1; k < SCENE_LATENCY; k++) begin
                tag_line[k] <= tag_line[k-1];
            end
        end
    end

    assign tag_out = tag_line[SCENE_LATENCY-1];

    // delayed select picks the object this point went to
    assign distance  = tag_out.sel ? box_dist : sphere_dist;
    assign valid_out = tag_out.sel ? box_vout : sphere_vout;

    // both object pipelines must agree with the select line
    a_valid_latency: assert property (@(posedge clk) disable iff (reset)
        valid_out == tag_out.valid);

endmodule

`default_nettype wire

/* source/sdf_box_frame.sv */
`timescale 1ns/1ps
`default_nettype none

module sdf_box_frame
    import sdf_pkg::*;
#(
    parameter fp FRAME_HALF = FP_ONE,
    parameter fp FRAME_EDGE = 32'h0040_0000
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      valid_in,
    input  wire vec3 p,
    output fp        distance,
    output logic     valid_out
);

    function automatic fp f_abs(fp a);
        return (a < 0) ? -a : a;
    endfunction

    function automatic fp f_max(fp a, fp b);
        return (a > b) ? a : b;
    endfunction

    function automatic fp f_min(fp a, fp b);
        return (a < b) ? a : b;
    endfunction

    // fold stage
    vec3  fold_p;
    logic fold_v;

    // offset stage, keeps the folded point too
    vec3  edge_p;
    vec3  edge_q;
    logic edge_v;

    // three candidates, one per bar direction
    vec3 cand     [3];
    vec3 cand_pos [3];
    fp   inner    [3];

    // length unit outputs
    fp        len       [3];
    fp        len_inner [3];
    logic [2:0] len_v;
    fp        sum       [3];

    always_ff @(posedge clk) begin
        if (reset) begin
            fold_v    <= 1'b0;
            edge_v    <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            fold_v    <= valid_in;
            edge_v    <= fold_v;
            valid_out <= len_v[0];
        end
    end

    always_ff @(posedge clk) begin
        // p = |p| - b
        fold_p.x <= f_abs(p.x) - FRAME_HALF;
        fold_p.y <= f_abs(p.y) - FRAME_HALF;
        fold_p.z <= f_abs(p.z) - FRAME_HALF;
        // q = |p + e| - e
        edge_p   <= fold_p;
        edge_q.x <= f_abs(fold_p.x + FRAME_EDGE) - FRAME_EDGE;
        edge_q.y <= f_abs(fold_p.y + FRAME_EDGE) - FRAME_EDGE;
        edge_q.z <= f_abs(fold_p.z + FRAME_EDGE) - FRAME_EDGE;
        // closest of the three bars
        distance <= f_min(sum[0], f_min(sum[1], sum[2]));
    end

    always_comb begin
        // each candidate takes one axis from p, the rest from q
        cand[0]   = edge_q;
        cand[0].x = edge_p.x;
        cand[1]   = edge_q;
        cand[1].y = edge_p.y;
        cand[2]   = edge_q;
        cand[2].z = edge_p.z;
        for (int i = 0; i < 3; i++) begin
            // outside part goes to the length unit
            cand_pos[i].x = f_max(cand[i].x, 0);
            cand_pos[i].y = f_max(cand[i].y, 0);
            cand_pos[i].z = f_max(cand[i].z, 0);
            // inside part, negative only when fully inside the bar
            inner[i] = f_min(f_max(cand[i].x, f_max(cand[i].y, cand[i].z)), 0);
        end
    end

    for (genvar i = 0; i < 3; i++) begin : g_len
        // inner term rides along as side payload
        vec_length #(
            .side_t (fp)
        ) u_len (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (edge_v),
            .v         (cand_pos[i]),
            .side_in   (inner[i]),
            .valid_out (len_v[i]),
            .len       (len[i]),
            .side_out  (len_inner[i])
        );

        // negative inner term means the whole candidate was clamped to zero
        a_inner_len: assert property (@(posedge clk) disable iff (reset)
            len_v[i] |-> (len_inner[i] >= 0 || len[i] == 0));
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            sum[i] = len[i] + len_inner[i];
        end
    end

endmodule

`default_nettype wire

/* source/sdf_pkg.sv */
`default_nettype none

package sdf_pkg;

    // signed Q8.24 scalar
    typedef logic signed [31:0] fp;

    // 1.0 in Q8.24
    localparam fp FP_ONE = 32'h0100_0000;

    // point or direction in scene space
    typedef struct packed {
        fp x;
        fp y;
        fp z;
    } vec3;

    // unsigned Q18.48 sum of three squares
    typedef logic [65:0] fp_sq;

    // one scene query
    // obj_sel 0 is the sphere, 1 is the box frame
    typedef struct packed {
        vec3  pos;
        logic obj_sel;
    } query_t;

    // cycles through vec_length
    // square and sum, then four root stages
    localparam int LEN_LATENCY = 5;

    // cycles from valid_in to valid_out of the scene query
    localparam int SCENE_LATENCY = 8;

endpackage

`default_nettype wire

/* source/sdf_sphere.sv */
`timescale 1ns/1ps
`default_nettype none

module sdf_sphere
    import sdf_pkg::*;
#(
    parameter fp SPHERE_RADIUS = FP_ONE
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      valid_in,
    input  wire vec3 p,
    output fp        distance,
    output logic     valid_out
);

    // radius stage plus balancing registers
    localparam int TAIL = SCENE_LATENCY - LEN_LATENCY;

    fp    len;
    logic len_vld;

    fp               tail_d [TAIL];
    logic [TAIL-1:0] tail_v;

    // sphere at the origin, only |p| needed
    vec_length u_len (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (valid_in),
        .v         (p),
        .side_in   (1'b0),
        .valid_out (len_vld),
        .len       (len),
        .side_out  ()
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            tail_v <= '0;
        end else begin
            tail_v <= {tail_v[TAIL-2:0], len_vld};
        end
    end

    // first tail stage subtracts the radius
    // the rest only delay to match the box frame
    always_ff @(posedge clk) begin
        tail_d[0] <= len - SPHERE_RADIUS;
        for (int k = 1; k < TAIL; k++) begin
            tail_d[k] <= tail_d[k-1];
        end
    end

    assign distance  = tail_d[TAIL-1];
    assign valid_out = tail_v[TAIL-1];

endmodule

`default_nettype wire

/* source/vec_length.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_length
    import sdf_pkg::*;
#(
    parameter type side_t = logic
) (
    input  wire        clk,
    input  wire        reset,
    input  wire        valid_in,
    input  wire vec3   v,
    input  wire side_t side_in,
    output logic       valid_out,
    output fp          len,
    output side_t      side_out
);

    // state of the digit-by-digit root between stages
    typedef struct packed {
        logic [63:0] rad;
        logic [35:0] rem;
        logic [31:0] root;
    } root_state_t;

    // eight result bits per call
    // radicand pairs shift out of the top of rad
    function automatic root_state_t root_step(root_state_t s);
        root_state_t n;
        logic [35:0] trial;
        n = s;
        for (int i = 0; i < 8; i++) begin
            n.rem = {n.rem[33:0], n.rad[63:62]};
            n.rad = {n.rad[61:0], 2'b00};
            trial = {2'b00, n.root, 2'b01};
            if (n.rem >= trial) begin
                n.rem  = n.rem - trial;
                n.root = {n.root[30:0], 1'b1};
            end else begin
                n.root = {n.root[30:0], 1'b0};
            end
        end
        return n;
    endfunction

    logic signed [63:0] sq_x;
    logic signed [63:0] sq_y;
    logic signed [63:0] sq_z;
    fp_sq               sum_sq;

    root_state_t            st [LEN_LATENCY];
    side_t                  sd [LEN_LATENCY];
    logic [LEN_LATENCY-1:0] vld;

    // squares are never negative
    assign sq_x   = 64'(v.x) * 64'(v.x);
    assign sq_y   = 64'(v.y) * 64'(v.y);
    assign sq_z   = 64'(v.z) * 64'(v.z);
    assign sum_sq = {2'b00, sq_x} + {2'b00, sq_y} + {2'b00, sq_z};

    always_ff @(posedge clk) begin
        if (reset) begin
            vld <= '0;
        end else begin
            vld <= {vld[LEN_LATENCY-2:0], valid_in};
        end
    end

    // stage 0 loads the sum, top two bits stay zero for components in range
    always_ff @(posedge clk) begin
        st[0] <= '{rad: sum_sq[63:0], rem: '0, root: '0};
        sd[0] <= side_in;
        for (int k = 1; k < LEN_LATENCY; k++) begin
            st[k] <= root_step(st[k-1]);
            sd[k] <= sd[k-1];
        end
    end

    // root of Q16.48 lands directly in Q8.24
    assign len       = st[LEN_LATENCY-1].root;
    assign side_out  = sd[LEN_LATENCY-1];
    assign valid_out = vld[LEN_LATENCY-1];

    // input too large for Q8.24 would show here
    a_len_sign: assert property (@(posedge clk) disable iff (reset)
        valid_out |-> !len[31]);

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
source/sdf_pkg.sv
source/vec_length.sv
source/sdf_sphere.sv
source/sdf_box_frame.sv
source/scene_query.sv
verif/clock_gen.sv
verif/tb_scene_query.sv

/* verif/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // synchronous reset, released on a rising edge
    initial begin
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* include/scene_ref.svh */
`ifndef SCENE_REF_SVH
`define SCENE_REF_SVH

// reference models for the scene query
// fp, fp_sq and vec3 come from sdf_pkg in the including module

function automatic fp ref_abs(fp a);
    return (a < 0) ? -a : a;
endfunction

function automatic fp ref_max(fp a, fp b);
    return (a > b) ? a : b;
endfunction

function automatic fp ref_min(fp a, fp b);
    return (a < b) ? a : b;
endfunction

// floor square root, bit by bit from the top
function automatic fp ref_isqrt(fp_sq s);
    logic [63:0] rem;
    logic [63:0] root;
    logic [63:0] bit_w;
    rem   = s[63:0];
    root  = '0;
    bit_w = 64'h4000_0000_0000_0000;
    while (bit_w > rem) begin
        bit_w = bit_w >> 2;
    end
    while (bit_w != 0) begin
        if (rem >= root + bit_w) begin
            rem  = rem - (root + bit_w);
            root = (root >> 1) + bit_w;
        end else begin
            root = root >> 1;
        end
        bit_w = bit_w >> 2;
    end
    return root[31:0];
endfunction

// length in Q8.24 from the Q16.48 sum of squares
function automatic fp ref_length(vec3 v);
    logic signed [63:0] sx;
    logic signed [63:0] sy;
    logic signed [63:0] sz;
    fp_sq               sum;
    sx  = 64'(v.x) * 64'(v.x);
    sy  = 64'(v.y) * 64'(v.y);
    sz  = 64'(v.z) * 64'(v.z);
    sum = {2'b00, sx} + {2'b00, sy} + {2'b00, sz};
    return ref_isqrt(sum);
endfunction

function automatic fp ref_sphere(vec3 p, fp r);
    return ref_length(p) - r;
endfunction

// fold, offset, then closest of three bar candidates
function automatic fp ref_box_frame(vec3 p, fp h, fp e);
    vec3 a;
    vec3 q;
    vec3 c;
    vec3 m;
    fp   d;
    fp   best;
    a.x  = ref_abs(p.x) - h;
    a.y  = ref_abs(p.y) - h;
    a.z  = ref_abs(p.z) - h;
    q.x  = ref_abs(a.x + e) - e;
    q.y  = ref_abs(a.y + e) - e;
    q.z  = ref_abs(a.z + e) - e;
    best = '0;
    for (int i = 0; i < 3; i++) begin
        c = q;
        if (i == 0) c.x = a.x;
        else if (i == 1) c.y = a.y;
        else c.z = a.z;
        m.x = ref_max(c.x, 0);
        m.y = ref_max(c.y, 0);
        m.z = ref_max(c.z, 0);
        d   = ref_length(m) + ref_min(ref_max(c.x, ref_max(c.y, c.z)), 0);
        if (i == 0 || d < best) best = d;
    end
    return best;
endfunction

`endif

/* verif/tb_scene_query.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_scene_query
    import sdf_pkg::*;
();

    `include "scene_ref.svh"

    localparam int RESET_CYCLES = 3;
    localparam int IDLE_CYCLES  = 6;
    localparam fp  FRAME_EDGE   = 32'h0040_0000;
    localparam int T_RESET      = 0;
    localparam int T_SPHERE     = 1;
    localparam int T_BOX        = 2;
    localparam int T_LAT        = 3;
    localparam int T_STREAM     = 4;

    // one row of the stimulus table
    typedef struct packed {
        vec3        pos;
        logic       sel;
        logic [3:0] gap;
        logic [2:0] test;
        fp          exp;
    } entry_t;

    // one point in flight
    typedef struct packed {
        fp           exp;
        logic [2:0]  test;
        logic [31:0] stamp;
    } pending_t;

    logic   clk;
    logic   reset;
    logic   valid_in;
    query_t query;
    fp      distance;
    logic   valid_out;

    entry_t   table_q [$];
    pending_t pending_q [$];
    string    test_name [5];
    int       total [5];
    int       checks [5];
    int       errs [5];
    int       seed = 32'h02e0_fb9f;
    int       cycle = 0;
    int       limit = 1000;
    int       pass_count = 0;
    int       fail_count = 0;

    clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clk (.clk(clk), .reset(reset));

    scene_query UUT (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (valid_in),
        .query     (query),
        .distance  (distance),
        .valid_out (valid_out)
    );

    function automatic vec3 mk(fp x, fp y, fp z);
        vec3 v;
        v.x = x;
        v.y = y;
        v.z = z;
        return v;
    endfunction

    // within +-4.0
    function automatic fp rand_coord();
        return $random(seed) % 32'sh0400_0000;
    endfunction

    function automatic vec3 rand_vec();
        return mk(rand_coord(), rand_coord(), rand_coord());
    endfunction

    function automatic fp model(vec3 p, logic sel);
        return sel ? ref_box_frame(p, FP_ONE, FRAME_EDGE) : ref_sphere(p, FP_ONE);
    endfunction

    task automatic add_entry(vec3 p, logic sel, int gap, int test, fp exp);
        entry_t e;
        e.pos  = p;
        e.sel  = sel;
        e.gap  = gap[3:0];
        e.test = test[2:0];
        e.exp  = exp;
        table_q.push_back(e);
        total[test]++;
    endtask

    task automatic add_ref(vec3 p, logic sel, int gap, int test);
        add_entry(p, sel, gap, test, model(p, sel));
    endtask

    task automatic load_table();
        vec3 p;
        // sphere, known results first
        add_entry(mk(0, 0, 0), 1'b0, 0, T_SPHERE, 32'hFF00_0000);
        add_entry(mk(32'h0200_0000, 0, 0), 1'b0, 0, T_SPHERE, 32'h0100_0000);
        add_entry(mk(0, -32'sh0300_0000, 0), 1'b0, 0, T_SPHERE, 32'h0200_0000);
        add_entry(mk(0, 0, 32'h0080_0000), 1'b0, 0, T_SPHERE, 32'hFF80_0000);
        add_entry(mk(32'h0300_0000, 32'h0400_0000, 0), 1'b0, 0, T_SPHERE, 32'h0400_0000);
        for (int i = 0; i < 6; i++) begin
            add_ref(rand_vec(), 1'b0, i % 3, T_SPHERE);
        end
        // box frame, corners sit on the frame
        add_entry(mk(FP_ONE, FP_ONE, FP_ONE), 1'b1, 0, T_BOX, 32'h0000_0000);
        add_entry(mk(-FP_ONE, FP_ONE, -FP_ONE), 1'b1, 0, T_BOX, 32'h0000_0000);
        add_ref(mk(0, 0, 0), 1'b1, 0, T_BOX);
        // inside the z bar, 0.1 from its faces
        add_entry(mk(32'h00E6_6666, 32'h00E6_6666, 0), 1'b1, 1, T_BOX, 32'hFFE6_6666);
        for (int i = 0; i < 6; i++) begin
            add_ref(rand_vec(), 1'b1, (i == 5) ? 10 : i % 2, T_BOX);
        end
        // isolated point for latency
        add_ref(rand_vec(), 1'b1, 10, T_LAT);
        // back to back, alternating objects
        for (int i = 0; i < 12; i++) begin
            p = rand_vec();
            add_ref(p, i[0], 0, T_STREAM);
        end
    endtask

    // junk on the query bus while nothing is valid
    task automatic drive_idle();
        int r;
        r = $random(seed);
        valid_in        <= 1'b0;
        query.pos       <= rand_vec();
        query.obj_sel   <= r[0];
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(posedge clk) begin
        if (cycle >= limit) begin
            $display("timeout: run stopped after %0d cycles", cycle);
            $display("sim failed");
            $finish;
        end
    end

    // outputs sampled on the falling edge
    always @(negedge clk) begin : monitor
        pending_t p;
        int       lat;
        logic     ok;
        if (valid_out !== 1'b0) begin
            if (pending_q.size() == 0) begin
                $display("error at %0t: valid_out high with no point outstanding", $time);
                fail_count++;
            end else begin
                p   = pending_q.pop_front();
                lat = cycle - int'(p.stamp);
                ok  = 1'b1;
                if (lat != SCENE_LATENCY) begin
                    $display("error at %0t: result came %0d cycles after its point, not %0d",
                             $time, lat, SCENE_LATENCY);
                    ok = 1'b0;
                end
                if (distance !== p.exp) begin
                    $display("mismatch at %0t: distance got %h expected %h",
                             $time, distance, p.exp);
                    ok = 1'b0;
                end
                if (ok) begin
                    pass_count++;
                end else begin
                    fail_count++;
                    errs[p.test]++;
                end
                checks[p.test]++;
                if (checks[p.test] == total[p.test]) begin
                    $display("test %0d %s: %0d points, %0d errors", p.test,
                             test_name[p.test], total[p.test], errs[p.test]);
                end
            end
        end
    end

    initial begin : driver
        int       max_gap;
        pending_t p;
        valid_in  <= 1'b1;
        query     <= '0;
        test_name = '{"reset", "sphere", "box frame", "latency", "streaming"};
        load_table();
        max_gap = 0;
        foreach (table_q[i]) begin
            if (int'(table_q[i].gap) > max_gap) max_gap = int'(table_q[i].gap);
        end
        limit = RESET_CYCLES + IDLE_CYCLES + table_q.size() * (max_gap + 1)
                + SCENE_LATENCY + 20;

        // points offered while reset is sampled high must all be dropped
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            drive_idle();
            valid_in <= 1'b1;
        end
        // the edge that releases reset samples these, so nothing valid
        repeat (IDLE_CYCLES + 1) begin
            @(posedge clk);
            drive_idle();
        end
        $display("test %0d %s: %0d errors while idle", T_RESET, test_name[T_RESET], fail_count);

        foreach (table_q[i]) begin
            @(posedge clk);
            valid_in      <= 1'b1;
            query.pos     <= table_q[i].pos;
            query.obj_sel <= table_q[i].sel;
            // cycle still holds the previous count here
            p.exp   = table_q[i].exp;
            p.test  = table_q[i].test;
            p.stamp = cycle + 1;
            pending_q.push_back(p);
            repeat (table_q[i].gap) begin
                @(posedge clk);
                drive_idle();
            end
        end
        @(posedge clk);
        drive_idle();

        // drain, then watch for extra results
        repeat (SCENE_LATENCY + 4) @(posedge clk);
        if (pending_q.size() != 0) begin
            $display("error: %0d points never returned a result", pending_q.size());
            fail_count++;
        end
        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
